//--- source/tetris_ai_pkg.sv
`default_nettype none

package tetris_ai_pkg;

  localparam int BOARD_ROWS = 20;
  localparam int BOARD_COLS = 10;
  localparam int NUM_MOVES  = 40;

  typedef logic [199:0]       board_t;   // Bit row*10+col, row 0 on top
  typedef logic [5:0]         move_id_t; // rotation*10 + column
  typedef logic [2:0]         piece_t;
  typedef logic [7:0]         count_t;
  typedef logic [2:0]         lines_t;
  typedef logic signed [17:0] score_t;

  typedef enum logic [2:0] {
    IDLE,
    PLACE,
    EXTRACT,
    SCORE,
    UPDATE,
    NEXT,
    FINISH
  } ctrl_state_t;

  // ------------------------------------------------------------------------
  // Shape table, 4x4 row-major mask packed to the top-left corner
  // ------------------------------------------------------------------------
  function automatic logic [15:0] piece_mask(input piece_t piece, input logic [1:0] rot,
                                             output logic [2:0] width,
                                             output logic [2:0] height);
    logic [15:0] mask;
    mask   = '0;
    width  = '0;
    height = '0;
    case (piece)
      3'd0: mask = rot[0] ? 16'h1111 : 16'h000F; // I
      3'd1: mask = 16'h0033;                     // O
      3'd2: begin                                // T
        case (rot)
          2'd0:    mask = 16'h0027;
          2'd1:    mask = 16'h0232;
          2'd2:    mask = 16'h0072;
          default: mask = 16'h0131;
        endcase
      end
      3'd3: mask = rot[0] ? 16'h0231 : 16'h0036; // S
      3'd4: mask = rot[0] ? 16'h0132 : 16'h0063; // Z
      3'd5: begin                                // J
        case (rot)
          2'd0:    mask = 16'h0071;
          2'd1:    mask = 16'h0113;
          2'd2:    mask = 16'h0047;
          default: mask = 16'h0322;
        endcase
      end
      3'd6: begin                                // L
        case (rot)
          2'd0:    mask = 16'h0074;
          2'd1:    mask = 16'h0311;
          2'd2:    mask = 16'h0017;
          default: mask = 16'h0223;
        endcase
      end
      default: mask = '0;                        // No such piece
    endcase
    // Bounding box from the filled cells
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        if (mask[r*4+c]) begin
          if (int'(width) < c + 1) width = 3'(c + 1);
          if (int'(height) < r + 1) height = 3'(r + 1);
        end
      end
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

//--- source/feature_if.sv
`default_nettype none

// Features of one candidate board, extractor to scorer
interface feature_if
  import tetris_ai_pkg::*;
();

  lines_t lines_cleared;
  count_t holes;
  count_t bumpiness;
  count_t height_sum;
  logic   done;          // One cycle, values valid from here on

  modport src (output lines_cleared, holes, bumpiness, height_sum, done);
  modport dst (input lines_cleared, holes, bumpiness, height_sum, done);

endinterface

`default_nettype wire

//--- source/placement_engine.sv
`default_nettype none

module placement_engine
  import tetris_ai_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       place_start,
  input  board_t     board,
  input  piece_t     piece,
  input  logic [1:0] rotation,
  input  logic [3:0] column,
  output logic       place_done,
  output logic       legal,
  output board_t     merged_board
);

  logic [15:0] shape_mask;
  logic [2:0]  shape_w;
  logic [2:0]  shape_h;
  board_t      cells_top;   // Piece at row 0
  board_t      cells_cur;   // Piece at the current drop row
  board_t      cells_next;  // Piece one row lower
  logic [4:0]  drop_row;
  logic        dropping;
  logic        start_ok;
  logic        can_step;

  // Piece cells on an otherwise empty board
  function automatic board_t place_cells(input logic [15:0] mask, input int row,
                                         input int col);
    board_t cells;
    cells = '0;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        if (mask[r*4+c] && (row + r < BOARD_ROWS) && (col + c < BOARD_COLS)) begin
          cells[(row + r) * BOARD_COLS + col + c] = 1'b1;
        end
      end
    end
    return cells;
  endfunction

  // ------------------------------------------------------------------------
  // Shape lookup and fit checks
  // ------------------------------------------------------------------------
  always_comb begin
    shape_mask = piece_mask(piece, rotation, shape_w, shape_h);
    cells_top  = place_cells(shape_mask, 0, int'(column));
    cells_cur  = place_cells(shape_mask, int'(drop_row), int'(column));
    cells_next = place_cells(shape_mask, int'(drop_row) + 1, int'(column));

    start_ok = (piece <= 3'd6) &&
               (int'(column) + int'(shape_w) <= BOARD_COLS) &&
               ((cells_top & board) == '0);

    // Next row must stay inside the board and be free
    can_step = (int'(drop_row) + 1 + int'(shape_h) <= BOARD_ROWS) &&
               ((cells_next & board) == '0);
  end

  // ------------------------------------------------------------------------
  // Drop control
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dropping   <= 1'b0;
      drop_row   <= '0;
      place_done <= 1'b0;
      legal      <= 1'b0;
    end else begin
      place_done <= 1'b0;
      if (dropping) begin
        if (can_step) begin
          drop_row <= drop_row + 5'd1;  // One row per cycle
        end else begin
          dropping   <= 1'b0;
          place_done <= 1'b1;
          legal      <= 1'b1;
        end
      end else if (place_start) begin
        if (start_ok) begin
          dropping <= 1'b1;
          drop_row <= '0;
        end else begin
          place_done <= 1'b1;           // Rejected right away
          legal      <= 1'b0;
        end
      end
    end
  end

  // Board with the piece at its resting row
  always_ff @(posedge clk) begin
    if (dropping && !can_step) begin
      merged_board <= board | cells_cur;
    end
  end

endmodule

`default_nettype wire

//--- source/feature_extract.sv
`default_nettype none

module feature_extract
  import tetris_ai_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  input  logic          extract_start,
  input  board_t        board,
  feature_if.src        feat
);

  logic [3:0] col_idx;
  logic       busy;
  logic [4:0] full_rows;
  lines_t     lines_sat;
  logic [4:0] col_height;   // 0..20
  logic [4:0] col_fill;     // Filled cells in the column
  logic [4:0] prev_height;
  logic [4:0] bump_step;

  // ------------------------------------------------------------------------
  // Full rows, counted once at start
  // ------------------------------------------------------------------------
  always_comb begin
    full_rows = '0;
    for (int r = 0; r < BOARD_ROWS; r++) begin
      if (&board[r*BOARD_COLS +: BOARD_COLS]) full_rows = full_rows + 5'd1;
    end
    lines_sat = (full_rows > 5'd7) ? 3'd7 : full_rows[2:0];  // Saturate
  end

  // ------------------------------------------------------------------------
  // Current column, scanned bottom up so the topmost cell wins
  // ------------------------------------------------------------------------
  always_comb begin
    col_height = '0;
    col_fill   = '0;
    for (int r = BOARD_ROWS - 1; r >= 0; r--) begin
      if (board[r*BOARD_COLS + int'(col_idx)]) begin
        col_height = 5'(BOARD_ROWS - r);
        col_fill   = col_fill + 5'd1;
      end
    end
    if (col_height >= prev_height) bump_step = col_height - prev_height;
    else bump_step = prev_height - col_height;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy               <= 1'b0;
      col_idx            <= '0;
      prev_height        <= '0;
      feat.done          <= 1'b0;
      feat.lines_cleared <= '0;
      feat.holes         <= '0;
      feat.bumpiness     <= '0;
      feat.height_sum    <= '0;
    end else begin
      feat.done <= 1'b0;
      if (!busy) begin
        if (extract_start) begin
          busy               <= 1'b1;
          col_idx            <= '0;
          prev_height        <= '0;
          feat.lines_cleared <= lines_sat;
          feat.holes         <= '0;
          feat.bumpiness     <= '0;
          feat.height_sum    <= '0;
        end
      end else begin
        // Empty cells under the top are holes
        feat.holes      <= feat.holes + {3'd0, col_height - col_fill};
        feat.height_sum <= feat.height_sum + {3'd0, col_height};
        if (col_idx != 4'd0) feat.bumpiness <= feat.bumpiness + {3'd0, bump_step};
        prev_height <= col_height;
        if (col_idx == 4'(BOARD_COLS - 1)) begin
          busy      <= 1'b0;
          feat.done <= 1'b1;
        end else begin
          col_idx <= col_idx + 4'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/move_scorer.sv
`default_nettype none

module move_scorer
  import tetris_ai_pkg::*;
#(
  parameter int W_LINES  = 8,
  parameter int W_HOLES  = 6,
  parameter int W_BUMP   = 1,
  parameter int W_HEIGHT = 1
) (
  input  logic   clk,
  input  logic   reset_n,
  feature_if.dst feat,
  output logic   score_done,
  output score_t score
);

  logic [1:0] step;
  logic       busy;
  score_t     weight;
  logic [7:0] operand;
  score_t     term;

  // One feature and its weight per step
  always_comb begin
    case (step)
      2'd0: begin
        weight  = score_t'(W_LINES);
        operand = {5'd0, feat.lines_cleared};
      end
      2'd1: begin
        weight  = score_t'(W_HOLES);
        operand = feat.holes;
      end
      2'd2: begin
        weight  = score_t'(W_BUMP);
        operand = feat.bumpiness;
      end
      default: begin
        weight  = score_t'(W_HEIGHT);
        operand = feat.height_sum;
      end
    endcase
    term = weight * $signed({10'd0, operand});
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy       <= 1'b0;
      step       <= '0;
      score      <= '0;
      score_done <= 1'b0;
    end else begin
      score_done <= 1'b0;
      if (!busy) begin
        if (feat.done) begin
          score <= term;            // Lines term is the positive one
          step  <= 2'd1;
          busy  <= 1'b1;
        end
      end else begin
        score <= score - term;      // Penalty terms
        if (step == 2'd3) begin
          busy       <= 1'b0;
          step       <= '0;
          score_done <= 1'b1;
        end else begin
          step <= step + 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/argmax_unit.sv
`default_nettype none

module argmax_unit
  import tetris_ai_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     arg_clear,
  input  logic     arg_update,
  input  move_id_t arg_move_id,
  input  score_t   arg_score,
  output move_id_t best_move_id,
  output score_t   best_score,
  output logic     move_found
);

  logic take_new;

  // Strictly greater, so an earlier (lower) move id keeps a tie
  assign take_new = arg_update && (!move_found || (arg_score > best_score));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      best_move_id <= '0;
      best_score   <= '0;
      move_found   <= 1'b0;
    end else if (arg_clear) begin
      best_move_id <= '0;
      best_score   <= '0;
      move_found   <= 1'b0;
    end else if (take_new) begin
      best_move_id <= arg_move_id;
      best_score   <= arg_score;
      move_found   <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/ai_move_select.sv
`default_nettype none

module ai_move_select
  import tetris_ai_pkg::*;
#(
  parameter int W_LINES  = 8,
  parameter int W_HOLES  = 6,
  parameter int W_BUMP   = 1,
  parameter int W_HEIGHT = 1
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               start,
  input  logic [199:0]       board,
  input  logic [2:0]         piece,
  output logic [5:0]         best_move_id,
  output logic signed [17:0] best_score,
  output logic               move_found,
  output logic               done
);

  ctrl_state_t state;
  board_t      board_q;
  piece_t      piece_q;
  move_id_t    move_id;
  logic [1:0]  rot;
  logic [3:0]  col;

  logic        place_start;
  logic        place_done;
  logic        legal;
  board_t      merged_board;
  logic        extract_start;
  logic        score_done;
  score_t      score;
  logic        arg_clear;
  logic        arg_update;
  move_id_t    arg_move_id;

  feature_if feat_bus ();

  // ------------------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------------------
  placement_engine i_place (
    .clk          (clk),
    .reset_n      (reset_n),
    .place_start  (place_start),
    .board        (board_q),
    .piece        (piece_q),
    .rotation     (rot),
    .column       (col),
    .place_done   (place_done),
    .legal        (legal),
    .merged_board (merged_board)
  );

  feature_extract i_extract (
    .clk           (clk),
    .reset_n       (reset_n),
    .extract_start (extract_start),
    .board         (merged_board),
    .feat          (feat_bus)
  );

  move_scorer #(
    .W_LINES  (W_LINES),
    .W_HOLES  (W_HOLES),
    .W_BUMP   (W_BUMP),
    .W_HEIGHT (W_HEIGHT)
  ) i_scorer (
    .clk        (clk),
    .reset_n    (reset_n),
    .feat       (feat_bus),
    .score_done (score_done),
    .score      (score)
  );

  argmax_unit i_argmax (
    .clk          (clk),
    .reset_n      (reset_n),
    .arg_clear    (arg_clear),
    .arg_update   (arg_update),
    .arg_move_id  (arg_move_id),
    .arg_score    (score),
    .best_move_id (best_move_id),
    .best_score   (best_score),
    .move_found   (move_found)
  );

  // ------------------------------------------------------------------------
  // Control FSM, one candidate at a time
  // ------------------------------------------------------------------------
  assign arg_clear   = (state == IDLE) && start;
  assign arg_update  = (state == UPDATE);
  assign arg_move_id = move_id;
  assign done        = (state == FINISH);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= IDLE;
      move_id       <= '0;
      rot           <= '0;
      col           <= '0;
      place_start   <= 1'b0;
      extract_start <= 1'b0;
    end else begin
      place_start   <= 1'b0;
      extract_start <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            move_id     <= '0;
            rot         <= '0;
            col         <= '0;
            place_start <= 1'b1;
            state       <= PLACE;
          end
        end
        PLACE: begin
          if (place_done) begin
            if (legal) begin
              extract_start <= 1'b1;
              state         <= EXTRACT;
            end else begin
              state <= NEXT;         // Skip illegal candidate
            end
          end
        end
        EXTRACT: if (feat_bus.done) state <= SCORE;
        SCORE:   if (score_done) state <= UPDATE;
        UPDATE:  state <= NEXT;
        NEXT: begin
          if (move_id == move_id_t'(NUM_MOVES - 1)) begin
            state <= FINISH;
          end else begin
            move_id <= move_id + 6'd1;
            if (col == 4'(BOARD_COLS - 1)) begin
              col <= '0;
              rot <= rot + 2'd1;
            end else begin
              col <= col + 4'd1;
            end
            place_start <= 1'b1;
            state       <= PLACE;
          end
        end
        FINISH:  state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Search inputs, held for the whole search
  always_ff @(posedge clk) begin
    if ((state == IDLE) && start) begin
      board_q <= board;
      piece_q <= piece;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// True when every shape cell lies on the board and on an empty cell
function automatic bit fits_at(input logic [199:0] brd, input logic [15:0] mask,
                               input int row, input int col);
  for (int r = 0; r < 4; r++) begin
    for (int c = 0; c < 4; c++) begin
      if (mask[r*4+c]) begin
        if (row + r > 19 || col + c > 9) return 1'b0;
        if (brd[(row + r) * 10 + col + c]) return 1'b0;
      end
    end
  end
  return 1'b1;
endfunction

// Legality and drop of one candidate
function automatic bit model_place(input logic [199:0] brd, input logic [2:0] pc,
                                   input int rot, input int col,
                                   output logic [199:0] merged);
  logic [15:0] mask;
  logic [2:0]  w;
  logic [2:0]  h;
  int          row;
  merged = brd;
  if (pc > 3'd6) return 1'b0;
  mask = piece_mask(pc, 2'(rot), w, h);
  if (col + int'(w) > 10) return 1'b0;
  if (!fits_at(brd, mask, 0, col)) return 1'b0;  // Blocked at the top
  row = 0;
  while (fits_at(brd, mask, row + 1, col)) row++;
  for (int r = 0; r < 4; r++) begin
    for (int c = 0; c < 4; c++) begin
      if (mask[r*4+c]) merged[(row + r) * 10 + col + c] = 1'b1;
    end
  end
  return 1'b1;
endfunction

// Weighted feature score of a merged board
function automatic int model_score(input logic [199:0] brd);
  int lines;
  int holes;
  int bump;
  int hsum;
  int prev;
  int top;
  int ht;
  lines = 0;
  holes = 0;
  bump  = 0;
  hsum  = 0;
  prev  = 0;
  for (int r = 0; r < 20; r++) begin
    if (&brd[r*10 +: 10]) lines++;
  end
  if (lines > 7) lines = 7;  // 3-bit count
  for (int c = 0; c < 10; c++) begin
    top = 20;
    for (int r = 19; r >= 0; r--) begin
      if (brd[r*10+c]) top = r;
    end
    ht = 20 - top;
    for (int r = top + 1; r < 20; r++) begin
      if (!brd[r*10+c]) holes++;
    end
    hsum += ht;
    if (c > 0) bump += (ht > prev) ? ht - prev : prev - ht;
    prev = ht;
  end
  return W_LINES * lines - W_HOLES * holes - W_BUMP * bump - W_HEIGHT * hsum;
endfunction

// Best of all 40 candidates with the lowest id winning a tie
function automatic void model_search(input logic [199:0] brd, input logic [2:0] pc,
                                     output int best_id, output int best_score,
                                     output bit found);
  logic [199:0] merged;
  int           s;
  best_id    = 0;
  best_score = 0;
  found      = 1'b0;
  for (int m = 0; m < 40; m++) begin
    if (model_place(brd, pc, m / 10, m % 10, merged)) begin
      s = model_score(merged);
      if (!found || s > best_score) begin
        best_id    = m;
        best_score = s;
        found      = 1'b1;
      end
    end
  end
endfunction

`endif

//--- tests/tb_ai_move_select.sv
`default_nettype none

module tb_ai_move_select
  import tetris_ai_pkg::*;
();

  localparam int W_LINES  = 8;
  localparam int W_HOLES  = 6;
  localparam int W_BUMP   = 1;
  localparam int W_HEIGHT = 1;
  localparam int TIMEOUT  = 4000;  // Cycles per search

  logic               clk;
  logic               reset_n;
  logic               start;
  logic [199:0]       board;
  logic [2:0]         piece;
  logic [5:0]         best_move_id;
  logic signed [17:0] best_score;
  logic               move_found;
  logic               done;

  logic [31:0] rng_state;
  int          error_count;
  int          test_count;
  int          failed_tests;

  `include "tb_model.svh"

  ai_move_select i_dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .start        (start),
    .board        (board),
    .piece        (piece),
    .best_move_id (best_move_id),
    .best_score   (best_score),
    .move_found   (move_found),
    .done         (done)
  );

  always #2 clk = ~clk;

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) $display("test %s passed", name);
    else begin
      $display("test %s failed", name);
      failed_tests++;
    end
  endtask

  task automatic pulse_start(input logic [199:0] brd, input logic [2:0] pc);
    @(negedge clk);
    board = brd;
    piece = pc;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_done(input string name, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      if (done) seen = 1'b1;
      cycles++;
    end
    if (!seen) begin
      $display("Test %s got no done pulse within %0d cycles", name, TIMEOUT);
      error_count++;
    end
  endtask

  task automatic compare_result(input string name, input logic [199:0] brd,
                                input logic [2:0] pc);
    int exp_id;
    int exp_score;
    bit exp_found;
    model_search(brd, pc, exp_id, exp_score, exp_found);
    check_value({name, " move_found"}, int'(exp_found), int'(move_found));
    if (exp_found) begin
      check_value({name, " best_move_id"}, exp_id, int'(best_move_id));
      check_value({name, " best_score"}, exp_score, int'(best_score));
    end
  endtask

  task automatic run_search(input string name, input logic [199:0] brd,
                            input logic [2:0] pc);
    int errors_before;
    bit seen;
    errors_before = error_count;
    pulse_start(brd, pc);
    wait_done(name, seen);
    if (seen) compare_result(name, brd, pc);
    report_test(name, errors_before);
  endtask

  // Second start during a search must be dropped
  task automatic busy_start_test(input logic [199:0] brd_a, input logic [199:0] brd_b);
    int errors_before;
    int pulses;
    bit seen;
    errors_before = error_count;
    pulses        = 0;
    pulse_start(brd_a, 3'd2);
    repeat (10) @(negedge clk);
    pulse_start(brd_b, 3'd5);
    wait_done("busy_start", seen);
    if (seen) begin
      pulses = 1;
      compare_result("busy_start", brd_a, 3'd2);
      for (int i = 0; i < TIMEOUT; i++) begin
        @(negedge clk);
        if (done) pulses++;
      end
    end
    check_value("busy_start done pulses", 1, pulses);
    report_test("busy_start", errors_before);
  endtask

  function automatic logic [199:0] random_board();
    logic [199:0] brd;
    int           hcol;
    brd = '0;
    for (int c = 0; c < 10; c++) begin
      hcol = int'(next_random() % 32'd13);
      for (int r = 20 - hcol; r < 20; r++) begin
        if (next_random() % 32'd10 < 32'd7) brd[r*10+c] = 1'b1;  // About 70 % fill
      end
    end
    return brd;
  endfunction

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin
    logic [199:0] brd;
    int           errors_before;
    clk          = 1'b0;
    reset_n      = 1'b0;
    start        = 1'b0;
    board        = '0;
    piece        = '0;
    rng_state    = 32'd11947;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    repeat (16) @(negedge clk);
    reset_n = 1'b1;

    errors_before = error_count;
    check_value("reset_state done", 0, int'(done));
    check_value("reset_state move_found", 0, int'(move_found));
    report_test("reset_state", errors_before);

    for (int p = 0; p < 7; p++) run_search($sformatf("empty_p%0d", p), '0, 3'(p));

    for (int i = 0; i < 40; i++) begin
      brd = random_board();
      run_search($sformatf("random_%0d", i), brd, 3'(next_random() % 32'd7));
    end

    // Bottom four rows full except one column that a vertical I fills
    for (int g = 0; g < 10; g += 3) begin
      brd = '0;
      for (int r = 16; r < 20; r++) begin
        for (int c = 0; c < 10; c++) begin
          if (c != g) brd[r*10+c] = 1'b1;
        end
      end
      run_search($sformatf("lines_gap%0d", g), brd, 3'd0);
    end

    brd      = '0;
    brd[9:0] = '1;  // Top row blocked
    run_search("no_move_row0", brd, 3'd3);
    run_search("no_move_piece7", '0, 3'd7);

    busy_start_test(random_board(), random_board());

    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+tests
source/tetris_ai_pkg.sv
source/feature_if.sv
source/placement_engine.sv
source/feature_extract.sv
source/move_scorer.sv
source/argmax_unit.sv
source/ai_move_select.sv
tests/tb_ai_move_select.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_ai_move_select
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

SOURCES := $(wildcard source/*.sv tests/*.sv tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
